// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbMultiCycleControl
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# build, run, then judge the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== rtl/controlRom.sv ====
module controlRom (
	input  mcCtrlPkg::state_e    state,
	output mcCtrlPkg::ctrlWord_t ctrl
);
	import mcCtrlPkg::*;

	// fields not named in a state stay low
	always_comb
	begin
		case (state)
			// PC+4 and instruction load
			ST_FETCH:    ctrl = '{pcWrite: 1'b1, memRead: 1'b1, irWrite: 1'b1, aluSrcB: 3'd1,
					default: '0};
			// branch target precomputed into ALUOut
			ST_DECODE:   ctrl = '{aluSrcB: 3'd3, default: '0};
			ST_MEMADDR:  ctrl = '{aluSrcA: 2'd1, aluSrcB: 3'd2, default: '0};
			ST_MEMREAD:  ctrl = '{iorD: 1'b1, memRead: 1'b1, default: '0};
			ST_MEMWB:    ctrl = '{memToReg: 1'b1, regWrite: 1'b1, default: '0};
			ST_MEMWRITE: ctrl = '{iorD: 1'b1, memWrite: 1'b1, default: '0};
			// funct decides the ALU operation
			ST_RFMT:     ctrl = '{aluOp: 2'd2, aluSrcA: 2'd1, default: '0};
			// rd is the destination
			ST_RFMT2:    ctrl = '{regWrite: 1'b1, regDst: 1'b1, default: '0};
			// zero-extended immediate
			ST_IFMTL:    ctrl = '{aluOp: 2'd3, aluSrcB: 3'd4, aluSrcA: 2'd1, default: '0};
			// sign-extended immediate
			ST_IFMTA:    ctrl = '{aluOp: 2'd3, aluSrcB: 3'd2, aluSrcA: 2'd1, default: '0};
			// rt is the destination
			ST_IFMT2:    ctrl = '{regWrite: 1'b1, default: '0};
			// compare in the ALU, PC from ALUOut when taken
			ST_BEQ:      ctrl = '{pcWriteBeq: 1'b1, pcSource: 3'd1, aluOp: 2'd1, aluSrcA: 2'd1,
					default: '0};
			ST_BNE:      ctrl = '{pcWriteBne: 1'b1, pcSource: 3'd1, aluOp: 2'd1, aluSrcA: 2'd1,
					default: '0};
			ST_JUMP:     ctrl = '{pcWrite: 1'b1, pcSource: 3'd2, default: '0};
			// link address goes to ra
			ST_JAL:      ctrl = '{pcWrite: 1'b1, wbSel: 3'd1, pcSource: 3'd2, aluOp: 2'd3,
					aluSrcB: 3'd5, regWrite: 1'b1, default: '0};
			ST_JR:       ctrl = '{pcWrite: 1'b1, pcSource: 3'd3, default: '0};
			// cop0 does the write itself
			ST_MTC0:     ctrl = '0;
			// cop0 register onto the write-back bus
			ST_MFC0:     ctrl = '{wbSel: 3'd3, regWrite: 1'b1, default: '0};
			// back to EPC
			ST_ERET:     ctrl = '{pcWrite: 1'b1, pcSource: 3'd5, default: '0};
			// jump to the handler vector
			ST_EXC:      ctrl = '{pcWrite: 1'b1, pcSource: 3'd4, default: '0};
			default:     ctrl = '0;
		endcase
	end

	// single memory port for instructions and data
	always_comb
	begin
		assert (!(ctrl.memRead && ctrl.memWrite))
			else $error("memRead and memWrite both high in %s", state.name());
	end

endmodule

// ==== rtl/excDetect.sv ====
`include "mcSettings.svh"

module excDetect (
	input  mcCtrlPkg::decodeInfo_t info,
	input  mcCtrlPkg::state_e      state,
	input  logic                   aluOverflow,
	input  logic                   excLevel,
	input  logic [`MC_IRQ_W-1:0]   pendingIrq,
	output logic                   irqPending,
	output logic                   ovfTrap,
	output mcCtrlPkg::cop0Ctrl_t   cop0
);
	import mipsIsaPkg::*;
	import mcCtrlPkg::*;

	// privileged cop0 classes
	logic privClass;
	// instructions that redirect the PC, so the next slot is a delay slot
	logic transferClass;
	excCause_e cause;

	// interrupts are masked while already in the handler
	assign irqPending = (|pendingIrq) && !excLevel;
	assign ovfTrap = info.ovfChecked && aluOverflow && !excLevel;

	assign privClass = info.instrClass inside {CL_MTC0, CL_MFC0, CL_ERET};
	assign transferClass = info.instrClass inside {CL_BEQ, CL_BNE, CL_JUMP, CL_JAL, CL_JR};

	// cause priority with the highest first
	always_comb
	begin
		if (info.instrClass == CL_SYSCALL)
			cause = CAUSE_SYS;
		else if (ovfTrap)
			cause = CAUSE_OVF;
		else if (info.instrClass == CL_RESERVED || privClass)
			cause = CAUSE_RI;
		else if (irqPending)
			cause = CAUSE_INT;
		else
			cause = CAUSE_RI;
	end

	always_comb
	begin
		cop0.regWrite = state == ST_MTC0;
		cop0.eret = state == ST_ERET;
		cop0.excOccurred = state == ST_EXC;
		// EPC follows the PC except while entering the handler
		cop0.pcOriginalWrite = state != ST_EXC;
		cop0.interrupted = (state == ST_EXC) && (cause == CAUSE_INT);
		cop0.branchDelay = transferClass;
		cop0.cause = cause;
	end

	// handler entry needs a live cause and never the last RI fallback
	always_comb
	begin
		if (state == ST_EXC)
			assert (ovfTrap || irqPending || privClass
				|| info.instrClass inside {CL_SYSCALL, CL_RESERVED})
				else $error("exception entry without a live cause");
	end

endmodule

// ==== rtl/instrDecoder.sv ====
module instrDecoder (
	input  mipsIsaPkg::opcode_e    op,
	input  mipsIsaPkg::funct_e     funct,
	input  mipsIsaPkg::cop0Fmt_e   fmt,
	output mcCtrlPkg::decodeInfo_t info
);
	import mipsIsaPkg::*;
	import mcCtrlPkg::*;

	always_comb
	begin
		// anything not matched below is a reserved instruction
		info.instrClass = CL_RESERVED;
		info.ovfChecked = 1'b0;
		case (op)
			OP_RFMT:
			begin
				// R-type splits on the function field
				case (funct)
					FN_JR:      info.instrClass = CL_JR;
					FN_SYSCALL: info.instrClass = CL_SYSCALL;
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU:
						info.instrClass = CL_MULDIV;
					FN_ADD, FN_SUB:
					begin
						info.instrClass = CL_RTYPE;
						info.ovfChecked = 1'b1;
					end
					// and, or, slt and friends
					default:    info.instrClass = CL_RTYPE;
				endcase
			end
			OP_J:   info.instrClass = CL_JUMP;
			OP_JAL: info.instrClass = CL_JAL;
			OP_BEQ: info.instrClass = CL_BEQ;
			OP_BNE: info.instrClass = CL_BNE;
			OP_LW:  info.instrClass = CL_LOAD;
			OP_SW:  info.instrClass = CL_STORE;
			// zero-extended immediates
			OP_ANDI, OP_ORI, OP_XORI:
				info.instrClass = CL_IMMLOGIC;
			OP_ADDI:
			begin
				info.instrClass = CL_IMMARITH;
				info.ovfChecked = 1'b1;
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI:
				info.instrClass = CL_IMMARITH;
			OP_COP0:
			begin
				// cop0 splits on the format field
				case (fmt)
					FMT_MT:  info.instrClass = CL_MTC0;
					FMT_MF:  info.instrClass = CL_MFC0;
					// only eret is defined in the CO group
					FMT_CO:  info.instrClass = (funct == FN_ERET) ? CL_ERET : CL_RESERVED;
					default: info.instrClass = CL_RESERVED;
				endcase
			end
			default: info.instrClass = CL_RESERVED;
		endcase
	end

endmodule

// ==== rtl/mcCtrlPkg.sv ====
package mcCtrlPkg;

	// multicycle FSM states
	typedef enum logic [5:0] {
		ST_FETCH, ST_DECODE,
		// memory reference path
		ST_MEMADDR, ST_MEMREAD, ST_MEMWB, ST_MEMWRITE,
		// register and immediate ALU paths
		ST_RFMT, ST_RFMT2, ST_IFMTL, ST_IFMTA, ST_IFMT2,
		// control transfers
		ST_BEQ, ST_BNE, ST_JUMP, ST_JAL, ST_JR,
		// coprocessor 0
		ST_MTC0, ST_MFC0, ST_ERET, ST_EXC
	} state_e;

	// what DECODE dispatches on
	typedef enum logic [3:0] {
		CL_RTYPE, CL_MULDIV, CL_JR, CL_SYSCALL,
		CL_LOAD, CL_STORE, CL_IMMLOGIC, CL_IMMARITH,
		CL_BEQ, CL_BNE, CL_JUMP, CL_JAL,
		CL_MTC0, CL_MFC0, CL_ERET, CL_RESERVED
	} instrClass_e;

	typedef struct packed {
		instrClass_e instrClass;
		// add, sub and addi trap on signed overflow
		logic        ovfChecked;
	} decodeInfo_t;

	// datapath strobes, one word per state
	typedef struct packed {
		logic       pcWrite;
		logic       pcWriteBeq;
		logic       pcWriteBne;
		logic       iorD;
		logic       memRead;
		logic       memWrite;
		logic       irWrite;
		logic       memToReg;
		logic [2:0] wbSel;
		logic [2:0] pcSource;
		logic [1:0] aluOp;
		logic [2:0] aluSrcB;
		logic [1:0] aluSrcA;
		logic       regWrite;
		logic       regDst;
	} ctrlWord_t;

	// strobes towards coprocessor 0
	typedef struct packed {
		logic                  regWrite;
		logic                  eret;
		logic                  excOccurred;
		logic                  pcOriginalWrite;
		logic                  interrupted;
		logic                  branchDelay;
		mipsIsaPkg::excCause_e cause;
	} cop0Ctrl_t;

endpackage

// ==== rtl/mcSettings.svh ====
`ifndef MC_SETTINGS_SVH
`define MC_SETTINGS_SVH

// instruction word fields seen by the control unit
`define MC_OP_W 6
`define MC_FUNCT_W 6
`define MC_FMT_W 5

// coprocessor 0 cause register code
`define MC_CAUSE_W 5
// external interrupt lines into cop0
`define MC_IRQ_W 8

`endif

// ==== rtl/mipsIsaPkg.sv ====
`include "mcSettings.svh"

package mipsIsaPkg;

	// major opcodes still handled by the control unit
	typedef enum logic [`MC_OP_W-1:0] {
		OP_RFMT  = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_COP0  = 6'h10,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// function codes that change the control flow
	// other R-type codes are plain ALU operations
	typedef enum logic [`MC_FUNCT_W-1:0] {
		FN_JR      = 6'h08,
		FN_SYSCALL = 6'h0c,
		FN_MULT    = 6'h18,
		FN_MULTU   = 6'h19,
		FN_DIV     = 6'h1a,
		FN_DIVU    = 6'h1b,
		FN_ADD     = 6'h20,
		FN_SUB     = 6'h22
	} funct_e;

	// eret lives in the cop0 CO group and shares the mult code
	localparam funct_e FN_ERET = FN_MULT;

	// rs field of a cop0 instruction
	typedef enum logic [`MC_FMT_W-1:0] {
		FMT_MF = 5'h00,
		FMT_MT = 5'h04,
		FMT_CO = 5'h10
	} cop0Fmt_e;

	// exception codes written into the cause register
	typedef enum logic [`MC_CAUSE_W-1:0] {
		CAUSE_INT = 5'd0,
		CAUSE_SYS = 5'd8,
		CAUSE_RI  = 5'd10,
		CAUSE_OVF = 5'd12
	} excCause_e;

endpackage

// ==== rtl/multiCycleControl.sv ====
`include "mcSettings.svh"

module multiCycleControl (
	input  logic                   iCLK,
	input  logic                   iRST,
	input  logic [`MC_OP_W-1:0]    iOp,
	input  logic [`MC_FUNCT_W-1:0] iFunct,
	input  logic [`MC_FMT_W-1:0]   iFmt,
	input  logic                   iUserMode,
	input  logic                   iExcLevel,
	input  logic                   iAluOverflow,
	input  logic [`MC_IRQ_W-1:0]   iPendingIrq,
	output mcCtrlPkg::ctrlWord_t   ctrl,
	output mcCtrlPkg::cop0Ctrl_t   cop0,
	output mcCtrlPkg::state_e      state
);
	import mipsIsaPkg::*;
	import mcCtrlPkg::*;

	decodeInfo_t info;
	// level signals from exception detection to the FSM
	logic irqPending;
	logic ovfTrap;

	// raw instruction fields, unknown codes included
	instrDecoder uDecoder (.op(opcode_e'(iOp)), .funct(funct_e'(iFunct)),
		.fmt(cop0Fmt_e'(iFmt)), .info(info));

	excDetect uExc (.info(info), .state(state), .aluOverflow(iAluOverflow),
		.excLevel(iExcLevel), .pendingIrq(iPendingIrq), .irqPending(irqPending),
		.ovfTrap(ovfTrap), .cop0(cop0));

	stateSequencer uSeq (.iCLK(iCLK), .iRST(iRST), .info(info), .userMode(iUserMode),
		.irqPending(irqPending), .ovfTrap(ovfTrap), .state(state));

	controlRom uRom (.state(state), .ctrl(ctrl));

endmodule

// ==== rtl/stateSequencer.sv ====
module stateSequencer (
	input  logic                   iCLK,
	input  logic                   iRST,
	input  mcCtrlPkg::decodeInfo_t info,
	input  logic                   userMode,
	input  logic                   irqPending,
	input  logic                   ovfTrap,
	output mcCtrlPkg::state_e      state
);
	import mcCtrlPkg::*;

	state_e nextState;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= ST_FETCH;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = ST_FETCH;
		case (state)
			ST_FETCH: nextState = ST_DECODE;
			ST_DECODE:
			begin
				case (info.instrClass)
					CL_RTYPE, CL_MULDIV: nextState = ST_RFMT;
					// transfers take a pending irq before they redirect
					CL_JR:       nextState = irqPending ? ST_EXC : ST_JR;
					CL_BEQ:      nextState = irqPending ? ST_EXC : ST_BEQ;
					CL_BNE:      nextState = irqPending ? ST_EXC : ST_BNE;
					CL_JUMP:     nextState = irqPending ? ST_EXC : ST_JUMP;
					CL_JAL:      nextState = irqPending ? ST_EXC : ST_JAL;
					// kernel syscall is a no-op here
					CL_SYSCALL:  nextState = userMode ? ST_EXC : ST_FETCH;
					CL_LOAD, CL_STORE: nextState = ST_MEMADDR;
					CL_IMMLOGIC: nextState = ST_IFMTL;
					CL_IMMARITH: nextState = ST_IFMTA;
					// privileged, trap from user mode
					CL_MTC0:     nextState = userMode ? ST_EXC : ST_MTC0;
					CL_MFC0:     nextState = userMode ? ST_EXC : ST_MFC0;
					CL_ERET:     nextState = userMode ? ST_EXC : ST_ERET;
					default:     nextState = ST_EXC;
				endcase
			end
			ST_MEMADDR: nextState = (info.instrClass == CL_LOAD) ? ST_MEMREAD : ST_MEMWRITE;
			ST_MEMREAD: nextState = ST_MEMWB;
			ST_MEMWB, ST_MEMWRITE:
				nextState = irqPending ? ST_EXC : ST_FETCH;
			// hi/lo ops finish in the execute cycle
			ST_RFMT: nextState = (info.instrClass == CL_MULDIV) ? ST_FETCH : ST_RFMT2;
			ST_IFMTL, ST_IFMTA:
				nextState = ST_IFMT2;
			// write-back cycles also catch overflow
			ST_RFMT2, ST_IFMT2:
				nextState = (ovfTrap || irqPending) ? ST_EXC : ST_FETCH;
			// single-cycle tails, EXC included
			default: nextState = ST_FETCH;
		endcase
	end

	// the state register never holds X once out of reset
	stateKnown: assert property (@(posedge iCLK) disable iff (iRST)
		!$isunknown(state));

	// handler entry lasts one cycle, then fetch from the vector
	excOneCycle: assert property (@(posedge iCLK) disable iff (iRST)
		state == ST_EXC |=> state == ST_FETCH);

endmodule

// ==== src.f ====
+incdir+rtl
rtl/mipsIsaPkg.sv
rtl/mcCtrlPkg.sv
rtl/instrDecoder.sv
rtl/excDetect.sv
rtl/stateSequencer.sv
rtl/controlRom.sv
rtl/multiCycleControl.sv
tests/tbMultiCycleControl.sv

// ==== tests/tbMultiCycleControl.sv ====
`include "mcSettings.svh"

module tbMultiCycleControl;
	timeunit 1ns;
	timeprecision 1ps;
	import mipsIsaPkg::*;
	import mcCtrlPkg::*;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 10;
	localparam int numVec = 41;
	// longest legal path is a load that traps in write-back
	localparam int maxCycles = 6;

	// one table row with the name kept apart
	typedef struct packed {
		logic [`MC_OP_W-1:0]    op;
		logic [`MC_FUNCT_W-1:0] funct;
		logic [`MC_FMT_W-1:0]   fmt;
		logic                   userMode;
		logic                   excLevel;
		logic                   aluOverflow;
		logic                   irq;
		logic [3:0]             cycles;
		logic                   trap;
		logic [`MC_CAUSE_W-1:0] cause;
	} vector_t;

	logic iCLK;
	logic iRST;
	logic [`MC_OP_W-1:0] iOp;
	logic [`MC_FUNCT_W-1:0] iFunct;
	logic [`MC_FMT_W-1:0] iFmt;
	logic iUserMode;
	logic iExcLevel;
	logic iAluOverflow;
	logic [`MC_IRQ_W-1:0] iPendingIrq;
	ctrlWord_t ctrl;
	cop0Ctrl_t cop0;
	state_e state;

	string names[numVec];
	vector_t vecs[numVec];
	int nVec = 0;
	int checks = 0;
	int errors = 0;
	logic [31:0] seed = 32'h667dec7f;

	multiCycleControl uut (.iCLK(iCLK), .iRST(iRST), .iOp(iOp), .iFunct(iFunct), .iFmt(iFmt),
		.iUserMode(iUserMode), .iExcLevel(iExcLevel), .iAluOverflow(iAluOverflow),
		.iPendingIrq(iPendingIrq), .ctrl(ctrl), .cop0(cop0), .state(state));

	initial
	begin
		iCLK = 1'b0;
		forever #(clkPeriod / 2) iCLK = ~iCLK;
	end

	// whole run is bounded by the worst path of every row plus reset
	initial
	begin
		#((numVec * maxCycles + resetCycles + 1) * clkPeriod);
		$display("watchdog expired, the FSM stopped returning to FETCH");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// flags are {userMode, excLevel, aluOverflow, irq}
	task automatic addVec(input string name, input logic [`MC_OP_W-1:0] op,
		input logic [`MC_FUNCT_W-1:0] funct, input logic [`MC_FMT_W-1:0] fmt,
		input logic [3:0] flags, input int cycles, input int trap,
		input logic [`MC_CAUSE_W-1:0] cause);
		names[nVec] = name;
		vecs[nVec] = '{op, funct, fmt, flags[3], flags[2], flags[1], flags[0], 4'(cycles),
			trap != 0, cause};
		nVec++;
	endtask

	// last cycle writes the register file for lw, R-type ALU, immediates, mfc0 and jal
	function automatic logic writesReg(input vector_t v);
		if (v.trap)
			return 1'b0;
		if (v.op == OP_RFMT)
			return !(v.funct inside {FN_JR, FN_SYSCALL, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
		if (v.op == OP_COP0)
			return v.fmt == FMT_MF;
		return v.op inside {OP_LW, OP_JAL, OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_ADDIU,
			OP_SLTI, OP_SLTIU, OP_LUI};
	endfunction

	// a trap here lands in a delay slot
	function automatic logic isTransfer(input vector_t v);
		return v.op inside {OP_BEQ, OP_BNE, OP_J, OP_JAL} || (v.op == OP_RFMT && v.funct == FN_JR);
	endfunction

	// apply one row and follow the FSM back to FETCH
	task automatic runVec(input int k);
		vector_t v;
		logic [`MC_IRQ_W-1:0] irqVal;
		int n;
		int regWrites;
		int memWrites;
		int cop0Writes;
		int erets;
		int excCycles;
		int epcHolds;
		logic lastRegWrite;
		logic lastMemWrite;
		logic sawExc;
		v = vecs[k];
		irqVal = '0;
		if (v.irq)
		begin
			// any nonzero mix of lines is a request
			seed = xorshift(seed);
			while (seed[`MC_IRQ_W-1:0] == '0)
				seed = xorshift(seed);
			irqVal = seed[`MC_IRQ_W-1:0];
		end
		while (state != ST_FETCH)
			@(negedge iCLK);
		// held from DECODE until the next FETCH like the IR
		@(posedge iCLK);
		iOp <= v.op;
		iFunct <= v.funct;
		iFmt <= v.fmt;
		iUserMode <= v.userMode;
		iExcLevel <= v.excLevel;
		iAluOverflow <= v.aluOverflow;
		iPendingIrq <= irqVal;
		n = 1;
		regWrites = 0;
		memWrites = 0;
		cop0Writes = 0;
		erets = 0;
		excCycles = 0;
		epcHolds = 0;
		lastRegWrite = 1'b0;
		lastMemWrite = 1'b0;
		sawExc = 1'b0;
		@(negedge iCLK);
		while (state != ST_FETCH && n <= maxCycles)
		begin
			n++;
			lastRegWrite = ctrl.regWrite;
			lastMemWrite = ctrl.memWrite;
			if (ctrl.regWrite)
				regWrites++;
			if (ctrl.memWrite)
				memWrites++;
			if (cop0.regWrite)
				cop0Writes++;
			if (cop0.eret)
				erets++;
			if (cop0.excOccurred)
				excCycles++;
			if (!cop0.pcOriginalWrite)
				epcHolds++;
			if (state == ST_EXC)
			begin
				sawExc = 1'b1;
				checkEq({names[k], " cause"}, 32'(v.cause), 32'(cop0.cause));
				checkEq({names[k], " interrupted"}, 32'(v.cause == CAUSE_INT),
					32'(cop0.interrupted));
				checkEq({names[k], " branchDelay"}, 32'(isTransfer(v)), 32'(cop0.branchDelay));
			end
			@(negedge iCLK);
		end
		if (state != ST_FETCH)
		begin
			errors++;
			$display("%s did not get back to FETCH within %0d cycles", names[k], n);
		end
		checkEq({names[k], " cycles"}, 32'(v.cycles), n);
		checkEq({names[k], " trap"}, 32'(v.trap), 32'(sawExc));
		checkEq({names[k], " excOccurred cycles"}, 32'(v.trap), excCycles);
		checkEq({names[k], " EPC hold cycles"}, 32'(v.trap), epcHolds);
		checkEq({names[k], " final regWrite"}, 32'(writesReg(v)), 32'(lastRegWrite));
		checkEq({names[k], " final memWrite"}, 32'(!v.trap && v.op == OP_SW),
			32'(lastMemWrite));
		if (!v.trap)
		begin
			// strobes only in the committing cycle
			checkEq({names[k], " regWrite cycles"}, 32'(writesReg(v)), regWrites);
			checkEq({names[k], " memWrite cycles"}, 32'(v.op == OP_SW), memWrites);
		end
		checkEq({names[k], " cop0 write cycles"},
			32'(v.op == OP_COP0 && v.fmt == FMT_MT && !v.userMode), cop0Writes);
		checkEq({names[k], " eret cycles"},
			32'(v.op == OP_COP0 && v.fmt == FMT_CO && v.funct == FN_ERET && !v.userMode), erets);
	endtask

	task automatic fillTable();
		// name, op, funct, fmt, flags, cycles, trap, cause
		addVec("add", OP_RFMT, FN_ADD, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("sub", OP_RFMT, FN_SUB, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("and", OP_RFMT, 6'h24, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("mult", OP_RFMT, FN_MULT, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("multu", OP_RFMT, FN_MULTU, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("div", OP_RFMT, FN_DIV, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("divu", OP_RFMT, FN_DIVU, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("jr", OP_RFMT, FN_JR, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("lw", OP_LW, 6'h00, FMT_MF, 4'b1000, 5, 0, CAUSE_INT);
		addVec("sw", OP_SW, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("andi", OP_ANDI, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("ori", OP_ORI, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("xori", OP_XORI, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("addi", OP_ADDI, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("addiu", OP_ADDIU, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("slti", OP_SLTI, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("sltiu", OP_SLTIU, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("lui", OP_LUI, 6'h00, FMT_MF, 4'b1000, 4, 0, CAUSE_INT);
		addVec("beq", OP_BEQ, 6'h00, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("bne", OP_BNE, 6'h00, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("j", OP_J, 6'h00, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("jal", OP_JAL, 6'h00, FMT_MF, 4'b1000, 3, 0, CAUSE_INT);
		addVec("mtc0 kernel", OP_COP0, 6'h00, FMT_MT, 4'b0000, 3, 0, CAUSE_INT);
		addVec("mfc0 kernel", OP_COP0, 6'h00, FMT_MF, 4'b0000, 3, 0, CAUSE_INT);
		addVec("eret kernel", OP_COP0, FN_ERET, FMT_CO, 4'b0000, 3, 0, CAUSE_INT);
		addVec("syscall kernel", OP_RFMT, FN_SYSCALL, FMT_MF, 4'b0000, 2, 0, CAUSE_INT);
		// traps and the same causes masked by the exception level
		addVec("add ovf", OP_RFMT, FN_ADD, FMT_MF, 4'b1010, 5, 1, CAUSE_OVF);
		addVec("add ovf exl", OP_RFMT, FN_ADD, FMT_MF, 4'b1110, 4, 0, CAUSE_INT);
		addVec("sub ovf", OP_RFMT, FN_SUB, FMT_MF, 4'b1010, 5, 1, CAUSE_OVF);
		addVec("addi ovf", OP_ADDI, 6'h00, FMT_MF, 4'b1010, 5, 1, CAUSE_OVF);
		addVec("beq irq", OP_BEQ, 6'h00, FMT_MF, 4'b1001, 3, 1, CAUSE_INT);
		addVec("beq irq exl", OP_BEQ, 6'h00, FMT_MF, 4'b1101, 3, 0, CAUSE_INT);
		// irq taken at the end of the write-back cycles
		addVec("andi irq", OP_ANDI, 6'h00, FMT_MF, 4'b1001, 5, 1, CAUSE_INT);
		addVec("lw irq", OP_LW, 6'h00, FMT_MF, 4'b1001, 6, 1, CAUSE_INT);
		addVec("sw irq", OP_SW, 6'h00, FMT_MF, 4'b1001, 5, 1, CAUSE_INT);
		addVec("mtc0 user", OP_COP0, 6'h00, FMT_MT, 4'b1000, 3, 1, CAUSE_RI);
		addVec("mfc0 user", OP_COP0, 6'h00, FMT_MF, 4'b1000, 3, 1, CAUSE_RI);
		addVec("eret user", OP_COP0, FN_ERET, FMT_CO, 4'b1000, 3, 1, CAUSE_RI);
		addVec("co reserved", OP_COP0, 6'h01, FMT_CO, 4'b0000, 3, 1, CAUSE_RI);
		addVec("reserved op", 6'h3f, 6'h00, FMT_MF, 4'b1000, 3, 1, CAUSE_RI);
		addVec("syscall user", OP_RFMT, FN_SYSCALL, FMT_MF, 4'b1000, 3, 1, CAUSE_SYS);
	endtask

	initial
	begin
		iRST = 1'b1;
		iOp = '0;
		iFunct = '0;
		iFmt = '0;
		iUserMode = 1'b0;
		iExcLevel = 1'b0;
		iAluOverflow = 1'b0;
		iPendingIrq = '0;
		fillTable();
		repeat (resetCycles) @(posedge iCLK);
		iRST <= 1'b0;
		// first cycle out of reset is a fetch
		@(negedge iCLK);
		checkEq("reset state", 32'(ST_FETCH), 32'(state));
		checkEq("reset ctrl strobes", 32'b1110000, 32'({ctrl.pcWrite, ctrl.memRead,
			ctrl.irWrite, ctrl.memWrite, ctrl.regWrite, ctrl.pcWriteBeq, ctrl.pcWriteBne}));
		checkEq("reset cop0 strobes", 32'b000100, 32'({cop0.regWrite, cop0.eret,
			cop0.excOccurred, cop0.pcOriginalWrite, cop0.interrupted, cop0.branchDelay}));
		for (int k = 0; k < nVec; k++)
		begin
			runVec(k);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
